/* sd_cmd_config.svh */
// frame lengths, response timeout and register addresses
// for the SD command-line controller

`ifndef SD_CMD_CONFIG_SVH
`define SD_CMD_CONFIG_SVH

`define SD_CMD_BITS        48   // start, transmission, index, argument, crc7, end
`define SD_SHORT_RSP_BITS  48   // R1, R3, R6, R7
`define SD_LONG_RSP_BITS   136  // R2
`define SD_RSP_FIELD_BITS  127  // stored response without framing bits
`define SD_NCR_MAX         64   // cycles allowed until the response start bit

`define SD_REG_CMD         3'd0
`define SD_REG_ARG         3'd1
`define SD_REG_STATUS      3'd2
`define SD_REG_RSP0        3'd4 // least significant response word
`define SD_REG_RSP1        3'd5
`define SD_REG_RSP2        3'd6
`define SD_REG_RSP3        3'd7

`endif

/* sd_cmd_pkg.sv */
// response kind and receiver state types

package sd_cmd_pkg;

  // response the host expects for a command
  typedef enum logic [1:0] {
    RSP_NONE  = 2'd0, // no response, command ends after the frame
    RSP_SHORT = 2'd1, // 48 bit response
    RSP_LONG  = 2'd2  // 136 bit response (R2)
  } rsp_kind_e;

  // response receiver states
  typedef enum logic [1:0] {
    IDLE       = 2'd0, // line not watched
    WAIT_START = 2'd1, // waiting for the card to pull cmd low
    SHIFT_IN   = 2'd2, // sampling frame bits
    FINISHED   = 2'd3  // result valid for one cycle
  } rx_state_e;

endpackage

/* sd_crc7.sv */
// serial CRC7 (x^7 + x^3 + 1) with clear, shift and hold

`timescale 1ns/1ps

module sd_crc7 (
  input  logic       sd_clk_i,
  input  logic       reset_i,
  input  logic       clear_i,  // zero the remainder
  input  logic       shift_i,  // take bit_i into the remainder
  input  logic       bit_i,
  output logic [6:0] crc_o
);

  logic [6:0] crc_q;
  logic       feedback;

  assign feedback = crc_q[6] ^ bit_i;

  always_ff @(posedge sd_clk_i) begin
    if (reset_i || clear_i) begin
      crc_q <= 7'd0;
    end else if (shift_i) begin
      crc_q <= {crc_q[5:3], crc_q[2] ^ feedback, crc_q[1:0], feedback}; // taps at x^3 and x^0
    end
  end

  assign crc_o = crc_q; // holds when not shifting

endmodule

/* sd_cmd_tx.sv */
// command frame serialiser with on-the-fly CRC7
// and start_listening pulse for the response receiver

`timescale 1ns/1ps

`include "sd_cmd_config.svh"

module sd_cmd_tx (
  input  logic        sd_clk_i,
  input  logic        reset_i,
  input  logic        cmd_start_i,
  input  logic [5:0]  cmd_index_i,
  input  logic [31:0] cmd_arg_i,
  output logic        cmd_o,
  output logic        cmd_oe_o,
  output logic        tx_done_o,        // end bit on the line
  output logic        start_listening_o // two cycles after the end bit
);

  localparam int unsigned HeadBits = `SD_CMD_BITS - 8; // bits covered by the crc

  logic [HeadBits-1:0] head_q;
  logic [5:0]          bit_cnt_q;
  logic                pending_q;   // frame loaded and first bit due next
  logic                oe_q;
  logic                cmd_q;
  logic                listen_d1_q;
  logic                listen_q;
  logic                launch;
  logic                active;
  logic                end_cycle;
  logic                crc_load;
  logic                crc_shift;
  logic [6:0]          crc;

  assign launch    = cmd_start_i;
  assign active    = pending_q | oe_q;
  assign end_cycle = oe_q & (bit_cnt_q == 6'(`SD_CMD_BITS));
  assign crc_load  = oe_q & (bit_cnt_q == 6'(HeadBits));   // crc follows the head
  assign crc_shift = active & (bit_cnt_q < 6'(HeadBits));

  always_ff @(posedge sd_clk_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
      oe_q      <= 1'b0;
      cmd_q     <= 1'b1; // idle high
      bit_cnt_q <= 6'd0;
    end else if (launch) begin
      pending_q <= 1'b1;
      bit_cnt_q <= 6'd0;
    end else if (active) begin
      pending_q <= 1'b0;
      if (end_cycle) begin
        oe_q  <= 1'b0;
        cmd_q <= 1'b1;
      end else begin
        oe_q      <= 1'b1;
        bit_cnt_q <= bit_cnt_q + 6'd1;
        cmd_q     <= crc_load ? crc[6] : head_q[HeadBits-1]; // msb first
      end
    end
  end

  // frame head that is later refilled with the remaining crc bits and the end bit
  always_ff @(posedge sd_clk_i) begin
    if (launch) begin
      head_q <= {1'b0, 1'b1, cmd_index_i, cmd_arg_i};
    end else if (crc_load) begin
      head_q <= {crc[5:0], 1'b1, {(HeadBits - 7){1'b0}}};
    end else if (active) begin
      head_q <= head_q << 1;
    end
  end

  always_ff @(posedge sd_clk_i) begin
    if (reset_i) begin
      listen_d1_q <= 1'b0;
      listen_q    <= 1'b0;
    end else begin
      listen_d1_q <= end_cycle;
      listen_q    <= listen_d1_q;
    end
  end

  sd_crc7 i_crc7 (
    .sd_clk_i (sd_clk_i),
    .reset_i  (reset_i),
    .clear_i  (launch),
    .shift_i  (crc_shift),
    .bit_i    (head_q[HeadBits-1]),
    .crc_o    (crc)
  );

  assign cmd_o             = cmd_q;
  assign cmd_oe_o          = oe_q;
  assign tx_done_o         = end_cycle;
  assign start_listening_o = listen_q;

endmodule

/* sd_rsp_rx.sv */
// response receiver for short and long responses
// with crc7 and end-bit check and start-bit timeout

`timescale 1ns/1ps

`include "sd_cmd_config.svh"

module sd_rsp_rx
  import sd_cmd_pkg::*;
(
  input  logic                          sd_clk_i,
  input  logic                          reset_i,
  input  rsp_kind_e                     rsp_kind_i,
  input  logic                          start_listening_i,
  input  logic                          cmd_i,
  output logic                          rsp_done_o,
  output logic [`SD_RSP_FIELD_BITS-1:0] rsp_field_o,
  output logic                          crc_ok_o,
  output logic                          end_bit_err_o,
  output logic                          timeout_o
);

  rx_state_e                     rx_state_d;
  rx_state_e                     rx_state_q;
  logic [7:0]                    bit_cnt_q;     // frame bit index, or wait cycles
  logic [`SD_RSP_FIELD_BITS-1:0] field_q;
  logic                          end_bit_err_q;
  logic                          timeout_q;
  logic                          is_long;
  logic                          listen_en;
  logic                          start_seen;
  logic                          wait_expired;
  logic                          last_bit;
  logic                          capture;
  logic                          crc_shift;
  logic [7:0]                    last_idx;
  logic [7:0]                    field_first;
  logic [7:0]                    crc_first;
  logic [7:0]                    crc_last;
  logic [6:0]                    crc;

  assign is_long   = (rsp_kind_i == RSP_LONG);
  assign listen_en = start_listening_i & (rsp_kind_i != RSP_NONE);

  // frame layout, index of the end bit and of the first stored bit
  assign last_idx    = is_long ? 8'(`SD_LONG_RSP_BITS - 1) : 8'(`SD_SHORT_RSP_BITS - 1);
  assign field_first = is_long ? 8'd8 : 8'd2;  // skip reserved bits of R2
  assign crc_first   = is_long ? 8'd8 : 8'd1;  // short: start bit fed on detection
  assign crc_last    = last_idx - 8'd8;        // bit before the crc7

  // the start_listening cycle already counts as the first sample
  assign start_seen   = ~cmd_i & ((rx_state_q == WAIT_START) |
                                  ((rx_state_q == IDLE) & listen_en));
  assign wait_expired = (rx_state_q == WAIT_START) & cmd_i &
                        (bit_cnt_q == 8'(`SD_NCR_MAX - 1));
  assign last_bit     = (rx_state_q == SHIFT_IN) & (bit_cnt_q == last_idx);
  assign capture      = (rx_state_q == SHIFT_IN) & (bit_cnt_q >= field_first) & ~last_bit;
  assign crc_shift    = (start_seen & ~is_long) |
                        ((rx_state_q == SHIFT_IN) & (bit_cnt_q >= crc_first) &
                         (bit_cnt_q <= crc_last));

  always_comb begin
    rx_state_d = rx_state_q;
    unique case (rx_state_q)
      IDLE: begin
        if (listen_en) begin
          rx_state_d = start_seen ? SHIFT_IN : WAIT_START;
        end
      end
      WAIT_START: begin
        if (start_seen) begin
          rx_state_d = SHIFT_IN;
        end else if (wait_expired) begin
          rx_state_d = FINISHED; // card stayed silent
        end
      end
      SHIFT_IN: begin
        if (last_bit) begin
          rx_state_d = FINISHED;
        end
      end
      FINISHED: rx_state_d = IDLE;
      default:  rx_state_d = IDLE;
    endcase
  end

  always_ff @(posedge sd_clk_i) begin
    if (reset_i) begin
      rx_state_q    <= IDLE;
      bit_cnt_q     <= 8'd0;
      end_bit_err_q <= 1'b0;
      timeout_q     <= 1'b0;
    end else begin
      rx_state_q <= rx_state_d;
      unique case (rx_state_q)
        IDLE: begin
          bit_cnt_q     <= 8'd1; // next sample is frame bit 1 or wait cycle 1
          end_bit_err_q <= 1'b0;
          timeout_q     <= 1'b0;
        end
        WAIT_START: begin
          bit_cnt_q <= start_seen ? 8'd1 : bit_cnt_q + 8'd1;
          if (wait_expired) begin
            timeout_q <= 1'b1;
          end
        end
        SHIFT_IN: begin
          bit_cnt_q <= bit_cnt_q + 8'd1;
          if (last_bit) begin
            end_bit_err_q <= ~cmd_i; // end bit must be 1
          end
        end
        default: ;
      endcase
    end
  end

  // short responses fill the low 45 bits, the rest stays zero
  always_ff @(posedge sd_clk_i) begin
    if (rx_state_q == IDLE) begin
      field_q <= '0;
    end else if (capture) begin
      field_q <= {field_q[`SD_RSP_FIELD_BITS-2:0], cmd_i};
    end
  end

  sd_crc7 i_crc7 (
    .sd_clk_i (sd_clk_i),
    .reset_i  (reset_i),
    .clear_i  (rx_state_q == FINISHED),
    .shift_i  (crc_shift),
    .bit_i    (cmd_i),
    .crc_o    (crc)
  );

  assign rsp_done_o    = (rx_state_q == FINISHED);
  assign rsp_field_o   = field_q;
  assign crc_ok_o      = rsp_done_o & ~timeout_q & (crc == field_q[6:0]);
  assign end_bit_err_o = end_bit_err_q;
  assign timeout_o     = timeout_q;

endmodule

/* sd_cmd_regs.sv */
// host register block: command, argument, status and response words

`timescale 1ns/1ps

`include "sd_cmd_config.svh"

module sd_cmd_regs
  import sd_cmd_pkg::*;
(
  input  logic                          sd_clk_i,
  input  logic                          reset_i,
  input  logic [2:0]                    reg_addr_i,
  input  logic                          reg_we_i,
  input  logic [31:0]                   reg_wdata_i,
  output logic [31:0]                   reg_rdata_o,
  output logic                          cmd_start_o,
  output logic [5:0]                    cmd_index_o,
  output logic [31:0]                   cmd_arg_o,
  output rsp_kind_e                     rsp_kind_o,
  input  logic                          tx_done_i,
  input  logic                          rsp_done_i,
  input  logic [`SD_RSP_FIELD_BITS-1:0] rsp_field_i,
  input  logic                          crc_ok_i,
  input  logic                          end_bit_err_i,
  input  logic                          timeout_i
);

  logic [5:0]                    index_q;
  logic [31:0]                   arg_q;
  logic [`SD_RSP_FIELD_BITS-1:0] rsp_q;
  rsp_kind_e                     kind_q;
  logic                          busy_q;
  logic                          start_q;
  logic                          rsp_valid_q;
  logic                          crc_ok_q;
  logic                          end_bit_err_q;
  logic                          timeout_q;
  logic                          launch;
  logic                          cmd_finished;
  logic                          rsp_capture;

  assign launch       = reg_we_i & (reg_addr_i == `SD_REG_CMD) & ~busy_q; // dropped while busy
  assign cmd_finished = busy_q & ((kind_q == RSP_NONE) ? tx_done_i : rsp_done_i);
  assign rsp_capture  = cmd_finished & (kind_q != RSP_NONE);

  always_ff @(posedge sd_clk_i) begin
    if (reset_i) begin
      busy_q        <= 1'b0;
      start_q       <= 1'b0;
      kind_q        <= RSP_NONE;
      rsp_valid_q   <= 1'b0;
      crc_ok_q      <= 1'b0;
      end_bit_err_q <= 1'b0;
      timeout_q     <= 1'b0;
    end else begin
      start_q <= launch;
      if (launch) begin
        busy_q        <= 1'b1;
        kind_q        <= rsp_kind_e'(reg_wdata_i[9:8]);
        rsp_valid_q   <= 1'b0;
        crc_ok_q      <= 1'b0;
        end_bit_err_q <= 1'b0;
        timeout_q     <= 1'b0;
      end else if (cmd_finished) begin
        busy_q <= 1'b0;
        if (rsp_capture) begin
          rsp_valid_q   <= ~timeout_i;
          crc_ok_q      <= crc_ok_i;
          end_bit_err_q <= end_bit_err_i;
          timeout_q     <= timeout_i;
        end
      end
    end
  end

  always_ff @(posedge sd_clk_i) begin
    if (launch) begin
      index_q <= reg_wdata_i[5:0];
    end
    if (reg_we_i && (reg_addr_i == `SD_REG_ARG)) begin
      arg_q <= reg_wdata_i;
    end
    if (rsp_capture) begin
      rsp_q <= rsp_field_i;
    end
  end

  always_comb begin
    unique case (reg_addr_i)
      `SD_REG_CMD:    reg_rdata_o = {22'd0, kind_q, 2'd0, index_q};
      `SD_REG_ARG:    reg_rdata_o = arg_q;
      `SD_REG_STATUS: reg_rdata_o = {27'd0, timeout_q, end_bit_err_q, crc_ok_q,
                                     rsp_valid_q, busy_q};
      `SD_REG_RSP0:   reg_rdata_o = rsp_q[31:0];
      `SD_REG_RSP1:   reg_rdata_o = rsp_q[63:32];
      `SD_REG_RSP2:   reg_rdata_o = rsp_q[95:64];
      `SD_REG_RSP3:   reg_rdata_o = {1'b0, rsp_q[126:96]}; // field is 127 bits
      default:        reg_rdata_o = 32'd0;
    endcase
  end

  assign cmd_start_o = start_q;
  assign cmd_index_o = index_q;
  assign cmd_arg_o   = arg_q;
  assign rsp_kind_o  = kind_q;

endmodule

/* sd_cmd_top.sv */
// command-line top: register block, command transmitter, response receiver

`timescale 1ns/1ps

`include "sd_cmd_config.svh"

module sd_cmd_top
  import sd_cmd_pkg::*;
(
  input  logic        sd_clk_i,
  input  logic        reset_i,
  input  logic [2:0]  reg_addr_i,
  input  logic        reg_we_i,
  input  logic [31:0] reg_wdata_i,
  output logic [31:0] reg_rdata_o,
  output logic        cmd_o,
  output logic        cmd_oe_o,
  input  logic        cmd_i
);

  logic                          cmd_start;
  logic [5:0]                    cmd_index;
  logic [31:0]                   cmd_arg;
  rsp_kind_e                     rsp_kind;
  logic                          tx_done;
  logic                          start_listening;
  logic                          rsp_done;
  logic [`SD_RSP_FIELD_BITS-1:0] rsp_field;
  logic                          crc_ok;
  logic                          end_bit_err;
  logic                          timeout;

  sd_cmd_regs i_regs (
    .sd_clk_i      (sd_clk_i),
    .reset_i       (reset_i),
    .reg_addr_i    (reg_addr_i),
    .reg_we_i      (reg_we_i),
    .reg_wdata_i   (reg_wdata_i),
    .reg_rdata_o   (reg_rdata_o),
    .cmd_start_o   (cmd_start),
    .cmd_index_o   (cmd_index),
    .cmd_arg_o     (cmd_arg),
    .rsp_kind_o    (rsp_kind),
    .tx_done_i     (tx_done),
    .rsp_done_i    (rsp_done),
    .rsp_field_i   (rsp_field),
    .crc_ok_i      (crc_ok),
    .end_bit_err_i (end_bit_err),
    .timeout_i     (timeout)
  );

  sd_cmd_tx i_cmd_tx (
    .sd_clk_i          (sd_clk_i),
    .reset_i           (reset_i),
    .cmd_start_i       (cmd_start),
    .cmd_index_i       (cmd_index),
    .cmd_arg_i         (cmd_arg),
    .cmd_o             (cmd_o),
    .cmd_oe_o          (cmd_oe_o),
    .tx_done_o         (tx_done),
    .start_listening_o (start_listening)
  );

  sd_rsp_rx i_rsp_rx (
    .sd_clk_i          (sd_clk_i),
    .reset_i           (reset_i),
    .rsp_kind_i        (rsp_kind),
    .start_listening_i (start_listening),
    .cmd_i             (cmd_i),
    .rsp_done_o        (rsp_done),
    .rsp_field_o       (rsp_field),
    .crc_ok_o          (crc_ok),
    .end_bit_err_o     (end_bit_err),
    .timeout_o         (timeout)
  );

endmodule

/* sd_cmd_chk.sv */
// CMD-line protocol assertions, bound to the command-line top

`timescale 1ns/1ps

module sd_cmd_chk (
  input logic sd_clk_i,
  input logic reset_i,
  input logic cmd_line_i,
  input logic cmd_oe_i,
  input logic rsp_done_i
);

  // line stays released high between frames
  idle_high_a: assert property (@(posedge sd_clk_i) disable iff (reset_i)
    !cmd_oe_i |-> cmd_line_i)
    else $error("cmd_o low while cmd_oe_o is low");

  reset_quiet_a: assert property (@(posedge sd_clk_i) reset_i |=> !cmd_oe_i)
    else $error("cmd_oe_o driven during reset");

  done_pulse_a: assert property (@(posedge sd_clk_i) disable iff (reset_i)
    rsp_done_i |=> !rsp_done_i)
    else $error("rsp_done longer than one cycle");

endmodule

bind sd_cmd_top sd_cmd_chk i_chk (
  .sd_clk_i   (sd_clk_i),
  .reset_i    (reset_i),
  .cmd_line_i (cmd_o),
  .cmd_oe_i   (cmd_oe_o),
  .rsp_done_i (rsp_done)
);

/* sd_cmd_tb.sv */
// testbench for the SD command-line top with clock, reset, card model,
// xorshift stimulus, scoreboard and watchdog

`timescale 1ns/1ps

`include "sd_cmd_config.svh"

module sd_cmd_tb
  import sd_cmd_pkg::*;
();

  localparam int NUM_CMDS       = 40;
  localparam int CYCLES_PER_CMD = 300;  // worst command is well below this
  localparam int CLK_PERIOD     = 100;
  localparam int IDLE_LIMIT     = 2 * `SD_NCR_MAX;
  localparam int WATCHDOG_NS    = (NUM_CMDS * CYCLES_PER_CMD + 20) * CLK_PERIOD;

  logic         sd_clk;
  logic         reset;
  logic [2:0]   reg_addr;
  logic         reg_we;
  logic [31:0]  reg_wdata;
  logic [31:0]  reg_rdata;
  logic         cmd_line;
  logic         cmd_oe;
  logic         cmd_in;
  logic [31:0]  rng_state;
  logic [127:0] exp_rsp;     // predicted RSP0..RSP3
  logic [4:0]   exp_status;  // timeout, end_bit_err, crc_ok, rsp_valid, busy
  logic         rsp_known;   // response words are undefined until the first capture
  int           err_count;

  sd_cmd_top i_dut (
    .sd_clk_i    (sd_clk),
    .reset_i     (reset),
    .reg_addr_i  (reg_addr),
    .reg_we_i    (reg_we),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (reg_rdata),
    .cmd_o       (cmd_line),
    .cmd_oe_o    (cmd_oe),
    .cmd_i       (cmd_in)
  );

  initial sd_clk = 1'b0;
  always #(CLK_PERIOD / 2) sd_clk = ~sd_clk;

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // CRC7 (x^7 + x^3 + 1) over data[nbits-1:0] taken msb first
  function automatic logic [6:0] crc7_of(input logic [119:0] data, input int nbits);
    logic [6:0] crc;
    logic       fb;
    crc = 7'd0;
    for (int i = nbits - 1; i >= 0; i--) begin
      fb  = crc[6] ^ data[i];
      crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    end
    return crc;
  endfunction

  task automatic stop_on_error(input string msg);
    err_count++;
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else
      stop_on_error($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic write_reg(input logic [2:0] addr, input logic [31:0] data);
    @(negedge sd_clk);
    reg_addr  = addr;
    reg_wdata = data;
    reg_we    = 1'b1;
    @(negedge sd_clk);
    reg_we = 1'b0;
  endtask

  task automatic read_reg(input logic [2:0] addr, output logic [31:0] data);
    @(negedge sd_clk);
    reg_addr = addr;
    @(negedge sd_clk);
    data = reg_rdata;
  endtask

  task automatic wait_idle();
    reg_addr = `SD_REG_STATUS;
    for (int n = 0; n <= IDLE_LIMIT; n++) begin
      @(negedge sd_clk);
      if (!reg_rdata[0]) begin
        return;
      end
    end
    stop_on_error("busy did not clear after the command was sent");
  endtask

  // runs one command and checks the frame, the card response and the registers
  task automatic run_command(input rsp_kind_e kind, input logic silent, input logic busy_write);
    logic [5:0]   idx;
    logic [31:0]  arg;
    logic [47:0]  exp_frame;
    logic [47:0]  got_frame;
    logic [135:0] frame;
    logic [119:0] content;
    logic [6:0]   crc;
    logic         ok;
    logic [31:0]  rdata;
    int           len;
    int           delay;
    idx       = 6'(next_rand());
    arg       = next_rand();
    delay     = 2 + int'(next_rand() % 32'd19);
    exp_frame = {1'b0, 1'b1, idx, arg, crc7_of({80'd0, 1'b0, 1'b1, idx, arg}, 40), 1'b1};
    write_reg(`SD_REG_ARG, arg);
    write_reg(`SD_REG_CMD, {22'd0, kind, 2'd0, idx});
    @(negedge sd_clk);
    check_value("cmd_oe_o before frame", 64'(cmd_oe), 64'd0);
    for (int k = 47; k >= 0; k--) begin
      @(negedge sd_clk);
      check_value("cmd_oe_o during frame", 64'(cmd_oe), 64'd1);
      got_frame[k] = cmd_line;
      reg_we       = busy_write && (k == 30); // second launch attempt that must be dropped
      reg_wdata    = next_rand();
    end
    @(negedge sd_clk);
    check_value("cmd_oe_o after frame", 64'(cmd_oe), 64'd0);
    check_value("cmd_o frame", 64'(got_frame), 64'(exp_frame));
    if (kind == RSP_NONE) begin
      exp_status = 5'b00000;
    end else if (silent) begin
      exp_status = 5'b10000;
      exp_rsp    = 128'd0;
      rsp_known  = 1'b1;
    end else begin
      content = 120'({next_rand(), next_rand(), next_rand(), next_rand()});
      if (kind == RSP_SHORT) begin
        len   = 48;
        crc   = crc7_of({80'd0, 2'b00, content[37:0]}, 40);
        frame = {88'd0, 2'b00, content[37:0], crc, 1'b1};
        ok    = (crc7_of({80'd0, frame[47:8]}, 40) == frame[7:1]);
        exp_rsp = {83'd0, frame[45:1]};
      end else begin
        len = 136;
        crc = crc7_of(content, 120);
        if (next_rand() % 32'd3 == 32'd0) begin
          crc = crc ^ (7'(next_rand()) | 7'd1); // corrupt at least one crc bit
        end
        frame = {2'b00, 6'h3f, content, crc, (next_rand() % 32'd3 != 32'd0)};
        ok    = (crc7_of(frame[127:8], 120) == frame[7:1]);
        exp_rsp = {1'b0, frame[127:1]};
      end
      exp_status = {1'b0, ~frame[0], ok, 1'b1, 1'b0};
      rsp_known  = 1'b1;
      repeat (delay - 1) @(negedge sd_clk);
      for (int k = len - 1; k >= 0; k--) begin
        @(negedge sd_clk);
        cmd_in = frame[k];
      end
      @(negedge sd_clk);
      cmd_in = 1'b1; // card releases the line
    end
    wait_idle();
    read_reg(`SD_REG_STATUS, rdata);
    check_value("STATUS", 64'(rdata), 64'(exp_status));
    if (rsp_known) begin
      for (int w = 0; w < 4; w++) begin
        read_reg(3'(`SD_REG_RSP0 + w), rdata);
        check_value($sformatf("RSP%0d", w), 64'(rdata), 64'(exp_rsp[32*w +: 32]));
      end
    end
    read_reg(`SD_REG_CMD, rdata);
    check_value("CMD", 64'(rdata), 64'({22'd0, kind, 2'd0, idx}));
    read_reg(`SD_REG_ARG, rdata);
    check_value("ARG", 64'(rdata), 64'(arg));
  endtask

  initial begin
    rsp_kind_e   kind;
    logic        silent;
    logic        busy_write;
    logic [31:0] rdata;
    int          sel;
    rng_state = 32'h5288_2eba;
    err_count = 0;
    rsp_known = 1'b0;
    exp_rsp   = 128'd0;
    reset     = 1'b1;
    reg_addr  = 3'd0;
    reg_we    = 1'b0;
    reg_wdata = 32'd0;
    cmd_in    = 1'b1; // idle high
    repeat (10) @(negedge sd_clk);
    reset = 1'b0;
    @(negedge sd_clk);
    check_value("cmd_oe_o after reset", 64'(cmd_oe), 64'd0);
    check_value("cmd_o after reset", 64'(cmd_line), 64'd1);
    read_reg(`SD_REG_STATUS, rdata);
    check_value("STATUS after reset", 64'(rdata), 64'd0);
    // first five commands cover each case once and the rest are random
    for (int i = 0; i < NUM_CMDS; i++) begin
      sel = (i < 5) ? i : int'(next_rand() % 32'd8);
      case (sel)
        0:       kind = RSP_NONE;
        1, 3, 6: kind = RSP_SHORT;
        default: kind = RSP_LONG;
      endcase
      silent     = (sel == 3);
      busy_write = (sel == 4) || ((i >= 5) && (next_rand() % 32'd4 == 32'd0));
      run_command(kind, silent, busy_write);
    end
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all commands completed");
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped by the watchdog");
  end

endmodule

/* sd_cmd.f */
+incdir+.
sd_cmd_pkg.sv
sd_crc7.sv
sd_cmd_tx.sv
sd_rsp_rx.sv
sd_cmd_regs.sv
sd_cmd_top.sv
sd_cmd_chk.sv
sd_cmd_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the SD command-line testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sd_cmd.f --top-module sd_cmd_tb -Mdir obj_dir \
  > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vsd_cmd_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
  exit 0
fi
exit 1
